// File: imem_pkg.sv
`default_nettype none

package imem_pkg;

  // Byte address and instruction word widths
  localparam int ADDR_BITS = 32;
  localparam int WORD_BITS = 32;

  // Direct-mapped geometry with one word per line
  localparam int OFFSET_BITS = 2;
  localparam int INDEX_BITS = 4;
  localparam int NUM_LINES = 1 << INDEX_BITS;
  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  // addi x0, x0, 0
  localparam word_t NOP_WORD = 32'h0000_0013;

  // Line index from address bits 5..2
  function automatic index_t addr_index(addr_t addr);
    return addr[OFFSET_BITS +: INDEX_BITS];
  endfunction

  // Tag from address bits 31..6
  function automatic tag_t addr_tag(addr_t addr);
    return addr[ADDR_BITS-1 -: TAG_BITS];
  endfunction

endpackage

`default_nettype wire

// File: imem_cache_if.sv
`default_nettype none
`timescale 1ns/1ps

// Turns CPU fetch pulses into valid/ready reads on the instruction cache.
// Hits complete without a stall; misses stall until one cycle after the
// refilled word comes back, so the CPU picks it up from a register.
module imem_cache_if (
  input  logic            clk,
  input  logic            rst_n,

  // CPU fetch side
  input  logic            imem_ren,
  input  imem_pkg::addr_t imem_raddr,
  output imem_pkg::word_t imem_rdata,
  output logic            imem_stall,

  // Cache read port
  output logic            cache_rd_valid,
  output imem_pkg::addr_t cache_rd_addr,
  input  logic            cache_rd_ready,
  input  imem_pkg::word_t cache_rd_data,
  input  logic            cache_rd_data_valid
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT_READY
  } state_t;

  state_t          state;
  state_t          state_next;

  logic            rd_start;
  logic            rd_fire;
  logic            rd_fire_q;
  logic            miss_detected;
  logic            miss_inflight;
  logic            return_hold;

  imem_pkg::addr_t addr_hold;
  imem_pkg::word_t rdata_hold;

  // An accepted read with no data one cycle later is a miss
  assign miss_detected = rd_fire_q && !cache_rd_data_valid && !miss_inflight;

  // New reads only start when no earlier fetch is still outstanding
  assign rd_start = (state == ST_IDLE) && imem_ren && !miss_inflight &&
                    !return_hold && !miss_detected;

  assign cache_rd_valid = rd_start || (state == ST_WAIT_READY);
  assign rd_fire = cache_rd_valid && cache_rd_ready;

  assign imem_stall = (state == ST_WAIT_READY) || miss_detected ||
                      miss_inflight || return_hold;

  // While stalled the registered address keeps the request stable
  assign cache_rd_addr = imem_stall ? addr_hold : imem_raddr;

  // Refused requests wait here with valid held high
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (rd_start && !cache_rd_ready) begin
          state_next = ST_WAIT_READY;
        end
      end
      ST_WAIT_READY: begin
        if (cache_rd_ready) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Miss tracking flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_fire_q     <= 1'b0;
      miss_inflight <= 1'b0;
      return_hold   <= 1'b0;
    end else begin
      rd_fire_q <= rd_fire;
      if (cache_rd_data_valid && miss_inflight) begin
        // Refill word arrived, stall one more cycle on the held copy
        miss_inflight <= 1'b0;
        return_hold   <= 1'b1;
      end else begin
        if (miss_detected) begin
          miss_inflight <= 1'b1;
        end
        return_hold <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start) begin
      addr_hold <= imem_raddr;
    end
  end

  // Last returned word holds a NOP until the first read comes back
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_hold <= imem_pkg::NOP_WORD;
    end else if (cache_rd_data_valid) begin
      rdata_hold <= cache_rd_data;
    end
  end

  // Live cache data wins over the held word
  assign imem_rdata = cache_rd_data_valid ? cache_rd_data : rdata_hold;

endmodule

`default_nettype wire

// File: icache.sv
`default_nettype none
`timescale 1ns/1ps

// Direct-mapped instruction cache, one 32-bit word per line.
// Misses refill from instruction memory over a four-phase req/ack port.
module icache (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,

  // Read port from the fetch bridge
  input  logic            rd_valid,
  input  imem_pkg::addr_t rd_addr,
  output logic            rd_ready,
  output imem_pkg::word_t rd_data,
  output logic            rd_data_valid,
  output logic            rd_hit,

  // Instruction memory port
  output logic            mem_req,
  output imem_pkg::addr_t mem_addr,
  input  logic            mem_ack,
  input  imem_pkg::word_t mem_rdata
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REQ,
    ST_RELEASE,
    ST_RESPOND
  } state_t;

  state_t           state;
  state_t           state_next;

  // Line storage
  imem_pkg::tag_t   tag_mem  [imem_pkg::NUM_LINES];
  imem_pkg::word_t  data_mem [imem_pkg::NUM_LINES];
  logic [imem_pkg::NUM_LINES-1:0] line_valid;

  imem_pkg::addr_t  req_addr;
  imem_pkg::index_t req_index;
  imem_pkg::tag_t   req_tag;
  imem_pkg::word_t  fill_data;

  logic             rd_fire;
  logic             lookup_hit;
  logic             refill_busy;
  logic             flush_pending;

  assign req_index = imem_pkg::addr_index(req_addr);
  assign req_tag = imem_pkg::addr_tag(req_addr);

  // Tag compare runs one cycle after the read was accepted
  assign lookup_hit = (state == ST_LOOKUP) && line_valid[req_index] &&
                      (tag_mem[req_index] == req_tag);

  // Hits keep the port open, so reads can follow back to back
  assign rd_ready = (state == ST_IDLE) || lookup_hit;
  assign rd_fire = rd_valid && rd_ready;

  assign rd_hit = lookup_hit;
  assign rd_data_valid = lookup_hit || (state == ST_RESPOND);
  assign rd_data = (state == ST_RESPOND) ? fill_data : data_mem[req_index];

  assign mem_req = (state == ST_REQ);
  assign mem_addr = {req_addr[imem_pkg::ADDR_BITS-1:imem_pkg::OFFSET_BITS],
                     {imem_pkg::OFFSET_BITS{1'b0}}};

  assign refill_busy = (state == ST_REQ) || (state == ST_RELEASE);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (rd_fire) begin
          state_next = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (!lookup_hit) begin
          state_next = ST_REQ;
        end else if (!rd_fire) begin
          state_next = ST_IDLE;
        end
      end
      // Req stays up until memory acknowledges
      ST_REQ: begin
        if (mem_ack) begin
          state_next = ST_RELEASE;
        end
      end
      // Wait for ack to fall before the port can be used again
      ST_RELEASE: begin
        if (!mem_ack) begin
          state_next = ST_RESPOND;
        end
      end
      ST_RESPOND: begin
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      req_addr <= rd_addr;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_REQ) && mem_ack) begin
      fill_data <= mem_rdata;
    end
  end

  // Line is written in the cycle the refill word is returned
  always_ff @(posedge clk) begin
    if (state == ST_RESPOND) begin
      tag_mem[req_index]  <= req_tag;
      data_mem[req_index] <= fill_data;
    end
  end

  // Valid bits and flush handling
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      line_valid    <= '0;
      flush_pending <= 1'b0;
    end else if (state == ST_RESPOND) begin
      // A flush seen during the refill also drops the new line
      if (flush_pending || flush) begin
        line_valid <= '0;
      end else begin
        line_valid[req_index] <= 1'b1;
      end
      flush_pending <= 1'b0;
    end else if (flush) begin
      if (refill_busy) begin
        flush_pending <= 1'b1;
      end else begin
        line_valid <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: imem_subsys.sv
`default_nettype none
`timescale 1ns/1ps

// Instruction fetch memory subsystem: fetch bridge in front of the cache
module imem_subsys (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,

  // CPU fetch port
  input  logic            imem_ren,
  input  imem_pkg::addr_t imem_raddr,
  output imem_pkg::word_t imem_rdata,
  output logic            imem_stall,

  // External instruction memory
  output logic            mem_req,
  output imem_pkg::addr_t mem_addr,
  input  logic            mem_ack,
  input  imem_pkg::word_t mem_rdata
);

  logic            cache_rd_valid;
  imem_pkg::addr_t cache_rd_addr;
  logic            cache_rd_ready;
  imem_pkg::word_t cache_rd_data;
  logic            cache_rd_data_valid;
  // Hit flag is observed only by the bound checks
  logic            cache_rd_hit;

  imem_cache_if u_imem_cache_if (
    .clk                 (clk),
    .rst_n               (rst_n),
    .imem_ren            (imem_ren),
    .imem_raddr          (imem_raddr),
    .imem_rdata          (imem_rdata),
    .imem_stall          (imem_stall),
    .cache_rd_valid      (cache_rd_valid),
    .cache_rd_addr       (cache_rd_addr),
    .cache_rd_ready      (cache_rd_ready),
    .cache_rd_data       (cache_rd_data),
    .cache_rd_data_valid (cache_rd_data_valid)
  );

  icache u_icache (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .rd_valid      (cache_rd_valid),
    .rd_addr       (cache_rd_addr),
    .rd_ready      (cache_rd_ready),
    .rd_data       (cache_rd_data),
    .rd_data_valid (cache_rd_data_valid),
    .rd_hit        (cache_rd_hit),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

endmodule

`default_nettype wire

// File: imem_subsys_asserts.sv
`default_nettype none
`timescale 1ns/1ps

// Protocol checks on the memory port and the fetch stall of imem_subsys
module imem_subsys_asserts (
  input logic            clk,
  input logic            rst_n,
  input logic            mem_req,
  input logic            mem_ack,
  input imem_pkg::addr_t mem_addr,
  input logic            imem_stall,
  input logic            cache_rd_hit
);

  // Req is held until memory acknowledges
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  // A new request waits for the previous ack to fall
  a_no_req_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req) |-> !mem_ack)
    else $error("mem_req raised while mem_ack was still high");

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && $past(mem_req) |-> $stable(mem_addr))
    else $error("mem_addr changed while mem_req was high");

  a_no_stall_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !imem_stall)
    else $error("imem_stall high in the first cycle after reset");

  // Hits take the stall-free path through the bridge
  a_hit_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
    cache_rd_hit |-> !imem_stall)
    else $error("imem_stall high during a cache hit");

endmodule

`default_nettype wire

// File: tb_imem_subsys.sv
`default_nettype none
`timescale 1ns/1ps

// Testbench for the instruction fetch subsystem.
// Models the CPU fetch stage and a four-phase instruction memory.
module tb_imem_subsys;

  localparam int CLK_PERIOD   = 8;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 5;

  // Instruction memory content is the address with this pattern XORed in
  localparam logic [31:0] MEM_XOR = 32'hA5A5_0000;

  logic            clk;
  logic            rst_n;
  logic            flush;
  logic            imem_ren;
  imem_pkg::addr_t imem_raddr;
  imem_pkg::word_t imem_rdata;
  logic            imem_stall;
  logic            mem_req;
  imem_pkg::addr_t mem_addr;
  logic            mem_ack;
  imem_pkg::word_t mem_rdata;

  // Vector storage
  logic            vec_flush [$];
  imem_pkg::addr_t vec_addr  [$];
  imem_pkg::word_t vec_word  [$];
  logic            vec_miss  [$];
  int              vec_count;
  logic            vectors_loaded = 1'b0;

  int              req_count;
  integer          seed;

  imem_subsys u_imem_subsys (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .imem_stall (imem_stall),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  bind imem_subsys imem_subsys_asserts u_imem_subsys_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_ack      (mem_ack),
    .mem_addr     (mem_addr),
    .imem_stall   (imem_stall),
    .cache_rd_hit (cache_rd_hit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic imem_pkg::word_t memory_word(imem_pkg::addr_t addr);
    return addr ^ MEM_XOR;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic load_vectors();
    integer          fd;
    int              n;
    logic            done;
    logic [63:0]     kind;
    logic [8*160-1:0] comment_buf;
    logic [31:0]     f_addr;
    logic [31:0]     f_word;
    logic [31:0]     f_miss;
    fd = $fopen("imem_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open imem_vectors.txt for reading");
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing vector file");
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", kind);
      if (n != 1) begin
        done = 1'b1;
      end else if (kind == 64'("fetch")) begin
        n = $fscanf(fd, "%h %h %d", f_addr, f_word, f_miss);
        if (n != 3) begin
          $display("A fetch record in imem_vectors.txt is incomplete");
          $display("TEST RESULT: FAIL");
          $fatal(1, "bad vector file");
        end
        vec_flush.push_back(1'b0);
        vec_addr.push_back(f_addr);
        vec_word.push_back(f_word);
        vec_miss.push_back(f_miss[0]);
      end else if (kind == 64'("flush")) begin
        vec_flush.push_back(1'b1);
        vec_addr.push_back('0);
        vec_word.push_back('0);
        vec_miss.push_back(1'b0);
      end else if (kind == 64'("#")) begin
        n = $fgets(comment_buf, fd);
      end else begin
        $display("Unknown record kind in imem_vectors.txt: %s", kind);
        $display("TEST RESULT: FAIL");
        $fatal(1, "bad vector file");
      end
    end
    $fclose(fd);
    vec_count = vec_flush.size();
    vectors_loaded = 1'b1;
  endtask

  // Called just after a rising edge, returns at the same point of the cycle
  task automatic pulse_flush();
    imem_ren = 1'b0;
    flush = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    flush = 1'b0;
  endtask

  // Issues one fetch and waits for the first cycle after acceptance without stall
  task automatic run_fetch(input int idx);
    int   reqs_before;
    int   cycles;
    logic stalled;
    imem_ren = 1'b1;
    imem_raddr = vec_addr[idx];
    reqs_before = req_count;
    cycles = 0;
    do begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end while (imem_stall);
    stalled = (cycles > 1);
    check($sformatf("vector %0d word", idx), vec_word[idx], imem_rdata);
    check($sformatf("vector %0d mem_req count", idx), {31'd0, vec_miss[idx]},
          req_count - reqs_before);
    check($sformatf("vector %0d stall", idx), {31'd0, vec_miss[idx]}, {31'd0, stalled});
  endtask

  // Instruction memory answers each request after 1 to 4 cycles
  initial begin : mem_responder
    int lat;
    mem_ack = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (rst_n && mem_req) begin
        lat = 1 + ($unsigned($random(seed)) % 4);
        repeat (lat) @(posedge clk);
        #DRIVE_DELAY;
        mem_rdata = memory_word(mem_addr);
        mem_ack = 1'b1;
        req_count++;
        // Ack stays up until the cache drops req
        do begin
          @(posedge clk);
          #DRIVE_DELAY;
        end while (mem_req);
        mem_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (vectors_loaded);
    limit = vec_count * 20 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    imem_ren = 1'b0;
    imem_raddr = '0;
    req_count = 0;
    seed = 10;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    for (int i = 0; i < vec_count; i++) begin
      if (vec_flush[i]) begin
        pulse_flush();
      end else begin
        run_fetch(i);
      end
    end
    imem_ren = 1'b0;
    repeat (4) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: imem_vectors.txt
# Fetch and flush sequence for the instruction fetch testbench
# fetch <addr hex> <expected word hex> <expected miss 0/1>, or flush
# Cold misses on lines 0 to 3
fetch 00000100 a5a50100 1
fetch 00000104 a5a50104 1
fetch 00000108 a5a50108 1
fetch 0000010c a5a5010c 1
# Back-to-back hits
fetch 00000100 a5a50100 0
fetch 00000104 a5a50104 0
fetch 00000108 a5a50108 0
fetch 0000010c a5a5010c 0
# Same index, different tags on line 0
fetch 00000500 a5a50500 1
fetch 00000100 a5a50100 1
fetch 00000500 a5a50500 1
fetch 00000500 a5a50500 0
# Eviction on line 1 and a fill of line 13
fetch 80000044 25a50044 1
fetch 00000104 a5a50104 1
fetch 00001234 a5a51234 1
# Flush drops every line
flush
fetch 00000500 a5a50500 1
fetch 00000104 a5a50104 1
fetch 00000108 a5a50108 1
fetch 0000010c a5a5010c 1
fetch 00001234 a5a51234 1
fetch 00000500 a5a50500 0
fetch 00000104 a5a50104 0
fetch 00000108 a5a50108 0
fetch 0000010c a5a5010c 0
fetch 00001234 a5a51234 0

// File: flist.f
imem_pkg.sv
imem_cache_if.sv
icache.sv
imem_subsys.sv
imem_subsys_asserts.sv
tb_imem_subsys.sv

// File: Makefile
# Verilator simulation of the instruction fetch subsystem

VERILATOR ?= verilator
TOP       ?= tb_imem_subsys
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
